// ==== Makefile ====
# Verilator build and run of the bin writeback testbench

VERILATOR ?= verilator
TOP       ?= bin_wb_tb
FILELIST  ?= bin_wb_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== bin_wb_top.f ====
hw/bin_pkg.sv
hw/bin_ram.sv
hw/bin_update.sv
hw/bin_csr.sv
hw/bin_wb_top.sv
dv/bin_wb_checker.sv
dv/bin_wb_tb.sv

// ==== dv/bin_stimulus.mem ====
// words 0-2: BIN_ID value, BASE_LVL value, unmapped address; words 3-42: map ids for slots 1-40
// then 5 records: bin id, base level, local_sat, 4 clauses / 8 var states, 8 level states
002a 00a5 05a3
0083 0086 0089 008c 008f 0092 0095 0098
00f8 009e 00c5 00a4 00a7 00aa 00ad 00b0
00b3 00b6 00b9 00bc 00bf 00c2 00a1 00c8
00cb 00ce 00d1 00d4 00d7 00da 00dd 00e0
00e3 00e6 00e9 00ec 00ef 00f2 00f5 009b
// update 0: bin 2, local_sat set
0002 0010 0001 1a01 1a52 1aa3 1af4
2b10 2b21 2b32 2b43 2b54 2b65 2b76 2b87 3c20 3c31 3c42 3c53 3c64 3c75 3c86 3c97
// update 1: bin 2 again, local_sat clear
0002 0010 0000 4d31 4d62 4d93 4dc4
5e40 5e51 5e62 5e73 5e84 5e95 5ea6 5eb7 6f50 6f61 6f72 6f83 6f94 6fa5 6fb6 6fc7
// update 2: bin 3
0003 0030 0001 7101 7132 7163 7194
8210 8221 8232 8243 8254 8265 8276 8287 9320 9331 9342 9353 9364 9375 9386 9397
// updates 3 and 4: bins 4 and 5 back to back
0004 0040 0001 a431 a462 a493 a4c4
b540 b551 b562 b573 b584 b595 b5a6 b5b7 c650 c661 c672 c683 c694 c6a5 c6b6 c6c7
0005 0050 0001 d761 d792 d7c3 d7f4
e870 e881 e892 e8a3 e8b4 e8c5 e8d6 e8e7 f980 f991 f9a2 f9b3 f9c4 f9d5 f9e6 f9f7

// ==== dv/bin_wb_checker.sv ====
//**********************************************************
// Wishbone read checker
// compares read data at ack and done pulses per test
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module bin_wb_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_ack_i,
    input  logic [15:0] wb_dat_i,
    input  logic        irq_i,
    input  logic        exp_valid_i,
    input  logic [15:0] exp_data_i,
    input  logic [11:0] exp_addr_i,
    input  logic [3:0]  exp_irqs_i,
    input  logic        test_end_i,
    input  logic [3:0]  test_num_i,
    input  logic        report_i,
    output int          error_count_o
);

    int   checks;
    int   errors;
    int   test_checks;
    int   test_errors;
    int   tests_run;
    int   tests_failed;
    int   irq_cycles;
    logic irq_bad;

    assign error_count_o = errors;

    // done is one cycle high for each accepted start
    assign irq_bad = (irq_cycles != int'(exp_irqs_i));

    always @(posedge clk) begin
        if (!rst) begin
            checks       <= 0;
            errors       <= 0;
            test_checks  <= 0;
            test_errors  <= 0;
            tests_run    <= 0;
            tests_failed <= 0;
            irq_cycles   <= 0;
        end else begin
            if (test_end_i) begin
                irq_cycles <= 0;
            end else if (irq_i) begin
                irq_cycles <= irq_cycles + 1;
            end
            if (wb_ack_i && exp_valid_i) begin
                checks      <= checks + 1;
                test_checks <= test_checks + 1;
                if (wb_dat_i !== exp_data_i) begin
                    errors      <= errors + 1;
                    test_errors <= test_errors + 1;
                    $display("Error at %0t ns: read of %03h returned %04h, expected %04h",
                             $time, exp_addr_i, wb_dat_i, exp_data_i);
                end
            end
            if (test_end_i) begin
                if (irq_bad) begin
                    errors <= errors + 1;
                    $display("Error at %0t ns: done pulse high for %0d cycles, expected %0d",
                             $time, irq_cycles, exp_irqs_i);
                end
                $display("test %0d %s: %0d reads checked, %0d mismatches", test_num_i,
                         (test_errors == 0 && !irq_bad) ? "ok" : "failed",
                         test_checks, test_errors);
                tests_run   <= tests_run + 1;
                test_checks <= 0;
                test_errors <= 0;
                if (test_errors != 0 || irq_bad) begin
                    tests_failed <= tests_failed + 1;
                end
            end
            if (report_i) begin
                $display("%0d tests, %0d failed, %0d reads checked, %0d errors",
                         tests_run, tests_failed, checks, errors);
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/bin_wb_tb.sv ====
//**********************************************************
// bin writeback testbench
// Wishbone host driver, engine data and RAM reference model
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module bin_wb_tb;

    localparam int TIMEOUT_CYCLES = 400 * 5;
    localparam int MAP_OFS = 3;
    localparam int REC_OFS = 43;
    localparam int REC_LEN = 23;

    logic         clk;
    logic         rst;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    logic [11:0]  wb_adr;
    logic [15:0]  wb_dat_w;
    logic [15:0]  wb_dat_r;
    logic         wb_ack;
    logic [63:0]  clauses;
    logic [127:0] var_states;
    logic [127:0] lvl_states;
    logic         local_sat;
    logic         irq;
    logic         exp_valid;
    logic [15:0]  exp_data;
    logic [11:0]  exp_addr;
    logic [3:0]   exp_irqs;
    logic         test_end;
    logic [3:0]   test_num;
    logic         report;
    int           error_count;
    int           cycles;
    logic [15:0]  stim [0:157];
    logic [15:0]  clause_m [0:255];
    logic [15:0]  vstate_m [0:255];
    logic [15:0]  lstate_m [0:255];
    logic [7:0]   map_m [0:255];

    bin_wb_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_dat_i     (wb_dat_w),
        .wb_dat_o     (wb_dat_r),
        .wb_ack_o     (wb_ack),
        .clauses_i    (clauses),
        .var_states_i (var_states),
        .lvl_states_i (lvl_states),
        .local_sat_i  (local_sat),
        .done_o       (irq)
    );

    bin_wb_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .wb_ack_i      (wb_ack),
        .wb_dat_i      (wb_dat_r),
        .irq_i         (irq),
        .exp_valid_i   (exp_valid),
        .exp_data_i    (exp_data),
        .exp_addr_i    (exp_addr),
        .exp_irqs_i    (exp_irqs),
        .test_end_i    (test_end),
        .test_num_i    (test_num),
        .report_i      (report),
        .error_count_o (error_count)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles without finishing", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [11:0] ram_adr(input logic [2:0] region, input logic [7:0] a);
        return {1'b0, region, a};
    endfunction

    function automatic int rec_ofs(input int r);
        return REC_OFS + r * REC_LEN;
    endfunction

    // bin n owns clause slots (n-1)*8+1 to (n-1)*8+8
    function automatic int bin_base_of(input int r);
        return (int'(stim[rec_ofs(r)][5:0]) - 1) * 8 + 1;
    endfunction

    task automatic bus_write(input logic [11:0] adr, input logic [15:0] dat);
        @(negedge clk);
        exp_valid = 1'b0;
        wb_cyc    = 1'b1;
        wb_stb    = 1'b1;
        wb_we     = 1'b1;
        wb_adr    = adr;
        wb_dat_w  = dat;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_read(input logic [11:0] adr, input logic [15:0] exp, input bit chk,
                            output logic [15:0] data);
        @(negedge clk);
        exp_valid = chk;
        exp_data  = exp;
        exp_addr  = adr;
        wb_cyc    = 1'b1;
        wb_stb    = 1'b1;
        wb_we     = 1'b0;
        wb_adr    = adr;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic read_check(input logic [11:0] adr, input logic [15:0] exp);
        logic [15:0] data;
        bus_read(adr, exp, 1'b1, data);
    endtask

    task automatic wait_done();
        logic [15:0] status;
        // first read can still show done of the previous update
        bus_read(12'h003, 16'h0, 1'b0, status);
        bus_read(12'h003, 16'h0, 1'b0, status);
        while (!status[1]) bus_read(12'h003, 16'h0, 1'b0, status);
    endtask

    // drive engine outputs, update the model, program bin id and base level
    task automatic load_update(input int r);
        int o;
        int base;
        int lvl;
        o    = rec_ofs(r);
        base = bin_base_of(r);
        lvl  = int'(stim[o+1][7:0]);
        @(negedge clk);
        local_sat = stim[o+2][0];
        for (int k = 0; k < 4; k++) begin
            clauses[k*16 +: 16] = stim[o+3+k];
            clause_m[base+4+k]  = stim[o+3+k];
        end
        for (int k = 0; k < 8; k++) begin
            var_states[k*16 +: 16] = stim[o+7+k];
            lvl_states[k*16 +: 16] = stim[o+15+k];
            if (local_sat) begin
                vstate_m[map_m[base+k]] = stim[o+7+k];
                lstate_m[lvl+k]         = stim[o+15+k];
            end
        end
        bus_write(12'h001, stim[o]);
        bus_write(12'h002, stim[o+1]);
    endtask

    task automatic check_bin(input int r);
        int base;
        int lvl;
        base = bin_base_of(r);
        lvl  = int'(stim[rec_ofs(r)+1][7:0]);
        for (int k = 0; k < 8; k++) begin
            read_check(ram_adr(bin_pkg::REGION_CLAUSE, 8'(base + k)), clause_m[base+k]);
            read_check(ram_adr(bin_pkg::REGION_VSTATE, map_m[base+k]),
                       vstate_m[map_m[base+k]]);
            read_check(ram_adr(bin_pkg::REGION_LSTATE, 8'(lvl + k)), lstate_m[lvl+k]);
        end
    endtask

    // irqs is the number of updates that the test starts
    task automatic end_test(input int n, input int irqs);
        @(negedge clk);
        test_num = 4'(n);
        exp_irqs = 4'(irqs);
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    task automatic preload();
        logic [7:0] id;
        int lvl;
        for (int a = 1; a <= 40; a++) begin
            id       = stim[MAP_OFS+a-1][7:0];
            map_m[a] = id;
            clause_m[a] = 16'h0;
            vstate_m[id] = 16'h0;
            bus_write(ram_adr(bin_pkg::REGION_VARMAP, 8'(a)), {8'h00, id});
            bus_write(ram_adr(bin_pkg::REGION_CLAUSE, 8'(a)), 16'h0);
            bus_write(ram_adr(bin_pkg::REGION_VSTATE, id), 16'h0);
        end
        for (int r = 0; r < 5; r++) begin
            lvl = int'(stim[rec_ofs(r)+1][7:0]);
            for (int k = 0; k < 8; k++) begin
                lstate_m[lvl+k] = 16'h0;
                bus_write(ram_adr(bin_pkg::REGION_LSTATE, 8'(lvl + k)), 16'h0);
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        clauses    = '0;
        var_states = '0;
        lvl_states = '0;
        local_sat  = 1'b0;
        exp_valid  = 1'b0;
        exp_data   = '0;
        exp_addr   = '0;
        exp_irqs   = '0;
        test_end   = 1'b0;
        test_num   = '0;
        report     = 1'b0;
        cycles     = 0;
        $readmemh("dv/bin_stimulus.mem", stim);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        if (^stim[157] !== 1'bx) begin
            // registers and unmapped space
            read_check(12'h003, 16'h0000);
            bus_write(12'h001, stim[0]);
            bus_write(12'h002, stim[1]);
            read_check(12'h001, stim[0] & 16'h003f);
            read_check(12'h002, stim[1] & 16'h00ff);
            read_check(stim[2][11:0], 16'h0000);
            read_check(12'h004, 16'h0000);
            end_test(1, 0);

            preload();
            load_update(0);
            bus_write(12'h000, 16'h0001);
            wait_done();
            check_bin(0);
            end_test(2, 1);

            load_update(1);
            bus_write(12'h000, 16'h0001);
            wait_done();
            check_bin(1);
            end_test(3, 1);

            // read right after start stalls behind the update
            load_update(2);
            bus_write(12'h000, 16'h0001);
            bus_write(12'h000, 16'h0001);
            read_check(ram_adr(bin_pkg::REGION_CLAUSE, 8'(bin_base_of(2) + 4)),
                       clause_m[bin_base_of(2)+4]);
            wait_done();
            read_check(12'h003, 16'h0002);
            check_bin(2);
            end_test(4, 1);

            load_update(3);
            bus_write(12'h000, 16'h0001);
            wait_done();
            load_update(4);
            bus_write(12'h000, 16'h0001);
            wait_done();
            check_bin(3);
            check_bin(4);
            end_test(5, 2);
        end

        @(negedge clk);
        report = 1'b1;
        @(negedge clk);
        report = 1'b0;
        if (^stim[157] !== 1'bx && error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            if (^stim[157] === 1'bx) begin
                $display("stimulus file dv/bin_stimulus.mem could not be read");
            end
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/bin_csr.sv ====
//**********************************************************
// Wishbone register block
// control/status registers and host windows into bin RAMs
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module bin_csr (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [bin_pkg::WB_ADR_W-1:0]   wb_adr_i,
    input  logic [bin_pkg::WB_DAT_W-1:0]   wb_dat_i,
    input  logic                           apply_i,
    input  logic                           done_i,
    input  logic [bin_pkg::CLAUSE_W-1:0]   clause_rd_i,
    input  logic [bin_pkg::VAR_ID_W-1:0]   varmap_rd_i,
    input  logic [bin_pkg::VAR_STATE_W-1:0] vstate_rd_i,
    input  logic [bin_pkg::LVL_STATE_W-1:0] lstate_rd_i,
    output logic [bin_pkg::WB_DAT_W-1:0]   wb_dat_o,
    output logic                           wb_ack_o,
    output logic                           start_o,
    output logic [bin_pkg::BIN_ID_W-1:0]   bin_id_o,
    output logic [bin_pkg::LVL_W-1:0]      base_lvl_o,
    output logic [bin_pkg::RAM_ADDR_W-1:0] host_addr_o,
    output logic [bin_pkg::WB_DAT_W-1:0]   host_data_o,
    output logic                           clause_we_o,
    output logic                           varmap_we_o,
    output logic                           vstate_we_o,
    output logic                           lstate_we_o
);

    bin_pkg::host_region_e          region;
    logic                           req;
    logic                           csr_hit;
    logic                           ram_hit;
    logic                           stall;
    logic                           ram_wr;
    logic                           ram_rd;
    logic                           rd_wait_q;
    logic                           start_req_q;
    logic                           busy_q;
    logic                           done_q;
    logic [bin_pkg::WB_DAT_W-1:0]   csr_rdata;
    logic [bin_pkg::WB_DAT_W-1:0]   ram_rdata;

    assign region  = bin_pkg::host_region_e'(wb_adr_i[10:8]);
    assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign csr_hit = !wb_adr_i[11] && (region == bin_pkg::REGION_CSR);

    // hold off RAM traffic from start until the sequencer lets go
    assign stall  = start_o || apply_i;
    assign ram_wr = req && ram_hit && wb_we_i && !stall;
    assign ram_rd = req && ram_hit && !wb_we_i && !stall && !rd_wait_q;

    assign host_addr_o = wb_adr_i[bin_pkg::RAM_ADDR_W-1:0];
    assign host_data_o = wb_dat_i;
    assign clause_we_o = ram_wr && (region == bin_pkg::REGION_CLAUSE);
    assign varmap_we_o = ram_wr && (region == bin_pkg::REGION_VARMAP);
    assign vstate_we_o = ram_wr && (region == bin_pkg::REGION_VSTATE);
    assign lstate_we_o = ram_wr && (region == bin_pkg::REGION_LSTATE);

    always_comb begin
        ram_hit   = 1'b0;
        ram_rdata = '0;
        if (!wb_adr_i[11]) begin
            case (region)
                bin_pkg::REGION_CLAUSE: begin
                    ram_hit   = 1'b1;
                    ram_rdata = clause_rd_i;
                end
                bin_pkg::REGION_VARMAP: begin
                    ram_hit   = 1'b1;
                    ram_rdata = {{(bin_pkg::WB_DAT_W-bin_pkg::VAR_ID_W){1'b0}}, varmap_rd_i};
                end
                bin_pkg::REGION_VSTATE: begin
                    ram_hit   = 1'b1;
                    ram_rdata = vstate_rd_i;
                end
                bin_pkg::REGION_LSTATE: begin
                    ram_hit   = 1'b1;
                    ram_rdata = lstate_rd_i;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        csr_rdata = '0;
        if (csr_hit) begin
            case (wb_adr_i[7:0])
                bin_pkg::CSR_BIN_ID:
                    csr_rdata = {{(bin_pkg::WB_DAT_W-bin_pkg::BIN_ID_W){1'b0}}, bin_id_o};
                bin_pkg::CSR_BASE_LVL:
                    csr_rdata = {{(bin_pkg::WB_DAT_W-bin_pkg::LVL_W){1'b0}}, base_lvl_o};
                bin_pkg::CSR_STATUS:
                    csr_rdata = {{(bin_pkg::WB_DAT_W-2){1'b0}}, done_q, busy_q};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_ack_o    <= 1'b0;
            rd_wait_q   <= 1'b0;
            start_req_q <= 1'b0;
            start_o     <= 1'b0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            bin_id_o    <= '0;
            base_lvl_o  <= '0;
        end else begin
            wb_ack_o    <= (req && !ram_hit) || ram_wr || rd_wait_q;
            rd_wait_q   <= ram_rd;
            start_req_q <= req && wb_we_i && csr_hit && wb_dat_i[0]
                        && (wb_adr_i[7:0] == bin_pkg::CSR_CTRL);
            // a start during an update is dropped
            start_o     <= start_req_q && !busy_q && !start_o;
            if (req && wb_we_i && csr_hit) begin
                if (wb_adr_i[7:0] == bin_pkg::CSR_BIN_ID) begin
                    bin_id_o <= wb_dat_i[bin_pkg::BIN_ID_W-1:0];
                end
                if (wb_adr_i[7:0] == bin_pkg::CSR_BASE_LVL) begin
                    base_lvl_o <= wb_dat_i[bin_pkg::LVL_W-1:0];
                end
            end
            if (start_o) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (done_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // read data lands with the ack
    always_ff @(posedge clk) begin
        if (rd_wait_q) begin
            wb_dat_o <= ram_rdata;
        end else if (req && !ram_hit) begin
            wb_dat_o <= csr_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/bin_pkg.sv ====
//**********************************************************
// bin writeback package
// bin sizes, field widths, sequencer states, host regions
//**********************************************************
`default_nettype none

package bin_pkg;

    // bin geometry
    localparam int NUM_CLAUSES_BIN = 8;
    localparam int NUM_LEARNT      = NUM_CLAUSES_BIN / 2;
    localparam int NUM_VARS_BIN    = 8;
    localparam int NUM_LVLS_BIN    = 8;

    // field widths
    localparam int CLAUSE_W    = 2 * NUM_VARS_BIN;
    localparam int VAR_ID_W    = 8;
    localparam int VAR_STATE_W = 16;
    localparam int LVL_STATE_W = 16;
    localparam int LVL_W       = 8;
    localparam int BIN_ID_W    = 6;
    localparam int RAM_ADDR_W  = 8;

    // 8 map/write steps plus map read and state write tail
    localparam int UPD_STEPS = NUM_VARS_BIN + 2;
    localparam int STEP_W    = 4;

    // host bus
    localparam int WB_ADR_W = 12;
    localparam int WB_DAT_W = 16;

    localparam logic [7:0] CSR_CTRL     = 8'h00;
    localparam logic [7:0] CSR_BIN_ID   = 8'h01;
    localparam logic [7:0] CSR_BASE_LVL = 8'h02;
    localparam logic [7:0] CSR_STATUS   = 8'h03;

    typedef enum logic [1:0] {
        UPD_IDLE,
        UPD_RUN,
        UPD_DONE
    } update_state_e;

    // decoded from wb_adr_i[10:8]
    typedef enum logic [2:0] {
        REGION_CSR    = 3'd0,
        REGION_CLAUSE = 3'd1,
        REGION_VARMAP = 3'd2,
        REGION_VSTATE = 3'd3,
        REGION_LSTATE = 3'd4
    } host_region_e;

endpackage

`default_nettype wire

// ==== hw/bin_ram.sv ====
//**********************************************************
// bin RAM, update write port ahead of host write port
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module bin_ram #(
    parameter int DATA_W = 16
) (
    input  logic                           clk,
    input  logic                           upd_sel_i,
    input  logic                           upd_we_i,
    input  logic [bin_pkg::RAM_ADDR_W-1:0] upd_addr_i,
    input  logic [DATA_W-1:0]              upd_data_i,
    input  logic                           host_we_i,
    input  logic [bin_pkg::RAM_ADDR_W-1:0] host_addr_i,
    input  logic [DATA_W-1:0]              host_data_i,
    output logic [DATA_W-1:0]              rd_data_o
);

    logic [DATA_W-1:0] mem [2**bin_pkg::RAM_ADDR_W];

    always_ff @(posedge clk) begin
        if (upd_we_i) begin
            mem[upd_addr_i] <= upd_data_i;
        end else if (host_we_i && !upd_sel_i) begin
            mem[host_addr_i] <= host_data_i;
        end
        // read port follows the update side during apply
        rd_data_o <= mem[upd_sel_i ? upd_addr_i : host_addr_i];
    end

endmodule

`default_nettype wire

// ==== hw/bin_update.sv ====
//**********************************************************
// bin update sequencer
// commits learnt clauses, variable and level states to RAMs
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module bin_update (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  start_i,
    input  logic [bin_pkg::BIN_ID_W-1:0]                          bin_id_i,
    input  logic [bin_pkg::LVL_W-1:0]                             base_lvl_i,
    input  logic                                                  local_sat_i,
    input  logic [bin_pkg::NUM_LEARNT*bin_pkg::CLAUSE_W-1:0]      clauses_i,
    input  logic [bin_pkg::NUM_VARS_BIN*bin_pkg::VAR_STATE_W-1:0] var_states_i,
    input  logic [bin_pkg::NUM_LVLS_BIN*bin_pkg::LVL_STATE_W-1:0] lvl_states_i,
    input  logic [bin_pkg::VAR_ID_W-1:0]                          varmap_data_i,
    output logic                                                  apply_o,
    output logic                                                  done_o,
    output logic                                                  clause_we_o,
    output logic [bin_pkg::RAM_ADDR_W-1:0]                        clause_addr_o,
    output logic [bin_pkg::CLAUSE_W-1:0]                          clause_data_o,
    output logic [bin_pkg::RAM_ADDR_W-1:0]                        varmap_addr_o,
    output logic                                                  vstate_we_o,
    output logic [bin_pkg::RAM_ADDR_W-1:0]                        vstate_addr_o,
    output logic [bin_pkg::VAR_STATE_W-1:0]                       vstate_data_o,
    output logic                                                  lstate_we_o,
    output logic [bin_pkg::RAM_ADDR_W-1:0]                        lstate_addr_o,
    output logic [bin_pkg::LVL_STATE_W-1:0]                       lstate_data_o
);

    bin_pkg::update_state_e           state_q;
    logic [bin_pkg::STEP_W-1:0]       step_q;
    logic [bin_pkg::RAM_ADDR_W-1:0]   bin_base;
    logic [bin_pkg::RAM_ADDR_W-1:0]   base_q;
    logic [bin_pkg::LVL_W-1:0]        lvl_q;
    logic                             run;
    logic                             map_vld_q;
    logic [2:0]                       map_idx_q;

    // slots of bin n start at (n-1)*8+1, slot 0 unused
    assign bin_base = bin_pkg::RAM_ADDR_W'(
        (bin_pkg::RAM_ADDR_W'(bin_id_i) - 1'b1) * bin_pkg::NUM_CLAUSES_BIN + 1);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= bin_pkg::UPD_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                bin_pkg::UPD_IDLE: begin
                    if (start_i) begin
                        state_q <= bin_pkg::UPD_RUN;
                        step_q  <= '0;
                    end
                end
                bin_pkg::UPD_RUN: begin
                    if (step_q == bin_pkg::STEP_W'(bin_pkg::UPD_STEPS - 1)) begin
                        state_q <= bin_pkg::UPD_DONE;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                default: state_q <= bin_pkg::UPD_IDLE;
            endcase
        end
    end

    // bin base and level base held for the whole update
    always_ff @(posedge clk) begin
        if (state_q == bin_pkg::UPD_IDLE && start_i) begin
            base_q <= bin_base;
            lvl_q  <= base_lvl_i;
        end
    end

    assign run     = (state_q == bin_pkg::UPD_RUN);
    assign apply_o = run;
    assign done_o  = (state_q == bin_pkg::UPD_DONE);

    // learnt clauses fill the upper half of the bin
    assign clause_we_o   = run && (step_q < bin_pkg::NUM_LEARNT);
    assign clause_addr_o = base_q + bin_pkg::RAM_ADDR_W'(bin_pkg::NUM_LEARNT)
                         + bin_pkg::RAM_ADDR_W'(step_q);
    assign clause_data_o = clauses_i[step_q[1:0]*bin_pkg::CLAUSE_W +: bin_pkg::CLAUSE_W];

    assign lstate_we_o   = run && (step_q < bin_pkg::NUM_LVLS_BIN) && local_sat_i;
    assign lstate_addr_o = bin_pkg::RAM_ADDR_W'(lvl_q) + bin_pkg::RAM_ADDR_W'(step_q);
    assign lstate_data_o = lvl_states_i[step_q[2:0]*bin_pkg::LVL_STATE_W +:
                                        bin_pkg::LVL_STATE_W];

    // map read for local var k, id comes back next cycle
    assign varmap_addr_o = base_q + bin_pkg::RAM_ADDR_W'(step_q);

    always_ff @(posedge clk) begin
        if (!rst) begin
            map_vld_q   <= 1'b0;
            vstate_we_o <= 1'b0;
        end else begin
            map_vld_q   <= run && (step_q < bin_pkg::NUM_VARS_BIN);
            vstate_we_o <= map_vld_q && local_sat_i;
        end
    end

    always_ff @(posedge clk) begin
        map_idx_q     <= step_q[2:0];
        vstate_addr_o <= varmap_data_i;
        vstate_data_o <= var_states_i[map_idx_q*bin_pkg::VAR_STATE_W +:
                                      bin_pkg::VAR_STATE_W];
    end

endmodule

`default_nettype wire

// ==== hw/bin_wb_top.sv ====
//**********************************************************
// bin writeback top, Wishbone host access to bin RAMs
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module bin_wb_top (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  wb_cyc_i,
    input  logic                                                  wb_stb_i,
    input  logic                                                  wb_we_i,
    input  logic [bin_pkg::WB_ADR_W-1:0]                          wb_adr_i,
    input  logic [bin_pkg::WB_DAT_W-1:0]                          wb_dat_i,
    output logic [bin_pkg::WB_DAT_W-1:0]                          wb_dat_o,
    output logic                                                  wb_ack_o,
    input  logic [bin_pkg::NUM_LEARNT*bin_pkg::CLAUSE_W-1:0]      clauses_i,
    input  logic [bin_pkg::NUM_VARS_BIN*bin_pkg::VAR_STATE_W-1:0] var_states_i,
    input  logic [bin_pkg::NUM_LVLS_BIN*bin_pkg::LVL_STATE_W-1:0] lvl_states_i,
    input  logic                                                  local_sat_i,
    output logic                                                  done_o
);

    logic                             start;
    logic [bin_pkg::BIN_ID_W-1:0]     bin_id;
    logic [bin_pkg::LVL_W-1:0]        base_lvl;
    logic                             apply;
    logic [bin_pkg::RAM_ADDR_W-1:0]   host_addr;
    logic [bin_pkg::WB_DAT_W-1:0]     host_data;
    logic                             host_clause_we;
    logic                             host_varmap_we;
    logic                             host_vstate_we;
    logic                             host_lstate_we;
    logic                             clause_we;
    logic [bin_pkg::RAM_ADDR_W-1:0]   clause_addr;
    logic [bin_pkg::CLAUSE_W-1:0]     clause_data;
    logic [bin_pkg::RAM_ADDR_W-1:0]   varmap_addr;
    logic                             vstate_we;
    logic [bin_pkg::RAM_ADDR_W-1:0]   vstate_addr;
    logic [bin_pkg::VAR_STATE_W-1:0]  vstate_data;
    logic                             lstate_we;
    logic [bin_pkg::RAM_ADDR_W-1:0]   lstate_addr;
    logic [bin_pkg::LVL_STATE_W-1:0]  lstate_data;
    logic [bin_pkg::CLAUSE_W-1:0]     clause_rd;
    logic [bin_pkg::VAR_ID_W-1:0]     varmap_rd;
    logic [bin_pkg::VAR_STATE_W-1:0]  vstate_rd;
    logic [bin_pkg::LVL_STATE_W-1:0]  lstate_rd;

    bin_csr u_csr (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .apply_i     (apply),
        .done_i      (done_o),
        .clause_rd_i (clause_rd),
        .varmap_rd_i (varmap_rd),
        .vstate_rd_i (vstate_rd),
        .lstate_rd_i (lstate_rd),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .start_o     (start),
        .bin_id_o    (bin_id),
        .base_lvl_o  (base_lvl),
        .host_addr_o (host_addr),
        .host_data_o (host_data),
        .clause_we_o (host_clause_we),
        .varmap_we_o (host_varmap_we),
        .vstate_we_o (host_vstate_we),
        .lstate_we_o (host_lstate_we)
    );

    bin_update u_update (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start),
        .bin_id_i      (bin_id),
        .base_lvl_i    (base_lvl),
        .local_sat_i   (local_sat_i),
        .clauses_i     (clauses_i),
        .var_states_i  (var_states_i),
        .lvl_states_i  (lvl_states_i),
        .varmap_data_i (varmap_rd),
        .apply_o       (apply),
        .done_o        (done_o),
        .clause_we_o   (clause_we),
        .clause_addr_o (clause_addr),
        .clause_data_o (clause_data),
        .varmap_addr_o (varmap_addr),
        .vstate_we_o   (vstate_we),
        .vstate_addr_o (vstate_addr),
        .vstate_data_o (vstate_data),
        .lstate_we_o   (lstate_we),
        .lstate_addr_o (lstate_addr),
        .lstate_data_o (lstate_data)
    );

    bin_ram #(.DATA_W(bin_pkg::CLAUSE_W)) u_clause_ram (
        .clk         (clk),
        .upd_sel_i   (apply),
        .upd_we_i    (clause_we),
        .upd_addr_i  (clause_addr),
        .upd_data_i  (clause_data),
        .host_we_i   (host_clause_we),
        .host_addr_i (host_addr),
        .host_data_i (host_data),
        .rd_data_o   (clause_rd)
    );

    // map is host-written only, sequencer just reads it
    bin_ram #(.DATA_W(bin_pkg::VAR_ID_W)) u_varmap_ram (
        .clk         (clk),
        .upd_sel_i   (apply),
        .upd_we_i    (1'b0),
        .upd_addr_i  (varmap_addr),
        .upd_data_i  ({bin_pkg::VAR_ID_W{1'b0}}),
        .host_we_i   (host_varmap_we),
        .host_addr_i (host_addr),
        .host_data_i (host_data[bin_pkg::VAR_ID_W-1:0]),
        .rd_data_o   (varmap_rd)
    );

    bin_ram #(.DATA_W(bin_pkg::VAR_STATE_W)) u_vstate_ram (
        .clk         (clk),
        .upd_sel_i   (apply),
        .upd_we_i    (vstate_we),
        .upd_addr_i  (vstate_addr),
        .upd_data_i  (vstate_data),
        .host_we_i   (host_vstate_we),
        .host_addr_i (host_addr),
        .host_data_i (host_data),
        .rd_data_o   (vstate_rd)
    );

    bin_ram #(.DATA_W(bin_pkg::LVL_STATE_W)) u_lstate_ram (
        .clk         (clk),
        .upd_sel_i   (apply),
        .upd_we_i    (lstate_we),
        .upd_addr_i  (lstate_addr),
        .upd_data_i  (lstate_data),
        .host_we_i   (host_lstate_we),
        .host_addr_i (host_addr),
        .host_data_i (host_data),
        .rd_data_o   (lstate_rd)
    );

endmodule

`default_nettype wire
